/* logic/soc_pkg.sv */
// SoC bus fabric definitions
package soc_pkg;

  // Bus widths
  localparam int DATA_W = 16;
  localparam int ADR_W  = 19;         // Word address, byte address bits 19:1
  localparam int SEL_W  = 2;
  localparam int MAP_W  = ADR_W + 1;  // tga on top of the word address

  // Address map as {tga, adr} where a slave hits when (addr & mask) == base
  localparam logic [MAP_W-1:0] ROM_BASE   = {1'b0, 19'h7ffe0};  // Mem 0xfffc0 - 0xfffff
  localparam logic [MAP_W-1:0] ROM_MASK   = {1'b1, 19'h7ffe0};
  localparam logic [MAP_W-1:0] GPIO_BASE  = {1'b1, 19'h07880};  // IO 0xf100 - 0xf103
  localparam logic [MAP_W-1:0] GPIO_MASK  = {1'b1, 19'h07ffe};
  localparam logic [MAP_W-1:0] TIMER_BASE = {1'b1, 19'h00020};  // IO 0x40 - 0x43
  localparam logic [MAP_W-1:0] TIMER_MASK = {1'b1, 19'h07ffe};

  // Boot ROM
  localparam int    ROM_WORDS = 32;
  localparam int    ROM_AW    = $clog2(ROM_WORDS);
  localparam string ROM_FILE  = "boot_rom.hex";

  // Power-on reset hold
  localparam int RST_HOLD_CYCLES = 32;
  localparam int RST_CNT_W       = $clog2(RST_HOLD_CYCLES + 1);

  // Interrupt line 0 is the timer tick and line 1 a switch change
  localparam int                NUM_IRQ      = 2;
  localparam int                IID_W        = $clog2(NUM_IRQ);
  localparam logic [DATA_W-1:0] IRQ_VEC_BASE = 16'd8;
  localparam logic [DATA_W-1:0] NMI_VECTOR   = 16'h0002;

  // Master request, held steady until ack
  typedef struct packed {
    logic [ADR_W-1:0]  adr;
    logic              tga;  // IO space
    logic              we;
    logic [SEL_W-1:0]  sel;
    logic [DATA_W-1:0] dat;
    logic              cyc;
    logic              stb;
  } bus_req_t;

  // Slave response
  typedef struct packed {
    logic [DATA_W-1:0] dat;
    logic              ack;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    SLV_ROM,
    SLV_GPIO,
    SLV_TIMER,
    SLV_DEFAULT
  } slave_e;

  // Timer registers by word address bit 0
  typedef enum logic {
    TMR_RELOAD = 1'b0,
    TMR_COUNT  = 1'b1
  } timer_reg_e;

  // GPIO registers by word address bit 0
  typedef enum logic {
    GPIO_SW_LED = 1'b0,
    GPIO_STATUS = 1'b1
  } gpio_reg_e;

endpackage

/* logic/reset_debounce.sv */
// Power-on reset hold
`timescale 1ns/1ps

module reset_debounce import soc_pkg::*; (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_o
);

  logic [RST_CNT_W-1:0] cnt_q;

  // Reload while the board reset is low, count down after release
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q     <= RST_CNT_W'(RST_HOLD_CYCLES);
      sys_rst_o <= 1'b1;
    end else begin
      if (cnt_q != '0)
        cnt_q <= cnt_q - 1'b1;
      sys_rst_o <= (cnt_q != '0);  // Drops one cycle after the count empties
    end
  end

  a_rst_held: assert property (@(posedge clk) !rst_lck |=> sys_rst_o);

endmodule

/* logic/bus_switch.sv */
// Bus address decoder and response mux
`timescale 1ns/1ps

module bus_switch import soc_pkg::*; (
  input  logic             clk,
  input  logic             rst_i,
  input  bus_req_t         m_req_i,
  output bus_rsp_t         m_rsp_o,
  output bus_req_t         rom_req_o,
  input  bus_rsp_t         rom_rsp_i,
  output bus_req_t         gpio_req_o,
  input  bus_rsp_t         gpio_rsp_i,
  output bus_req_t         tmr_req_o,
  input  bus_rsp_t         tmr_rsp_i,
  input  logic             inta_i,
  input  logic             nmia_i,
  input  logic [IID_W-1:0] iid_i
);

  logic [MAP_W-1:0] map_adr;
  slave_e           slv;
  logic             def_stb;
  logic             def_ack_q;
  bus_rsp_t         sel_rsp;

  function automatic logic hit(input logic [MAP_W-1:0] adr,
                               input logic [MAP_W-1:0] base,
                               input logic [MAP_W-1:0] mask);
    return (adr & mask) == base;
  endfunction

  assign map_adr = {m_req_i.tga, m_req_i.adr};

  always_comb begin
    if (hit(map_adr, ROM_BASE, ROM_MASK))
      slv = SLV_ROM;
    else if (hit(map_adr, GPIO_BASE, GPIO_MASK))
      slv = SLV_GPIO;
    else if (hit(map_adr, TIMER_BASE, TIMER_MASK))
      slv = SLV_TIMER;
    else
      slv = SLV_DEFAULT;  // Unmapped space
  end

  // Same request to every slave but only the selected one sees cyc and stb
  always_comb begin
    rom_req_o      = m_req_i;
    gpio_req_o     = m_req_i;
    tmr_req_o      = m_req_i;
    rom_req_o.cyc  = m_req_i.cyc & (slv == SLV_ROM);
    rom_req_o.stb  = m_req_i.stb & (slv == SLV_ROM);
    gpio_req_o.cyc = m_req_i.cyc & (slv == SLV_GPIO);
    gpio_req_o.stb = m_req_i.stb & (slv == SLV_GPIO);
    tmr_req_o.cyc  = m_req_i.cyc & (slv == SLV_TIMER);
    tmr_req_o.stb  = m_req_i.stb & (slv == SLV_TIMER);
  end

  assign def_stb = m_req_i.cyc & m_req_i.stb & (slv == SLV_DEFAULT);

  // Default slave acks like the others and reads zero
  always_ff @(posedge clk) begin
    if (rst_i)
      def_ack_q <= 1'b0;
    else
      def_ack_q <= def_stb & ~def_ack_q;
  end

  always_comb begin
    case (slv)
      SLV_ROM:   sel_rsp = rom_rsp_i;
      SLV_GPIO:  sel_rsp = gpio_rsp_i;
      SLV_TIMER: sel_rsp = tmr_rsp_i;
      default:   sel_rsp = '{dat: '0, ack: def_ack_q};
    endcase
  end

  // Acknowledge cycles override the bus read data
  always_comb begin
    m_rsp_o.ack = sel_rsp.ack;
    if (nmia_i)
      m_rsp_o.dat = NMI_VECTOR;
    else if (inta_i)
      m_rsp_o.dat = IRQ_VEC_BASE + DATA_W'(iid_i);
    else
      m_rsp_o.dat = sel_rsp.dat;
  end

  a_one_stb: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0({rom_req_o.stb, gpio_req_o.stb, tmr_req_o.stb, def_stb}));

endmodule

/* logic/boot_rom.sv */
// Boot ROM slave
`timescale 1ns/1ps

module boot_rom import soc_pkg::*; (
  input  logic     clk,
  input  logic     rst_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  logic [DATA_W-1:0] mem [ROM_WORDS];
  logic [DATA_W-1:0] dat_q;
  logic              ack_q;

  initial begin
    $readmemh(ROM_FILE, mem);
  end

  // Low address bits index the image
  always_ff @(posedge clk) begin
    dat_q <= mem[req_i.adr[ROM_AW-1:0]];
  end

  // Writes get an ack and leave the contents alone
  always_ff @(posedge clk) begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= req_i.cyc & req_i.stb & ~ack_q;
  end

  assign rsp_o.dat = dat_q;
  assign rsp_o.ack = ack_q;

endmodule

/* logic/gpio_port.sv */
// Switch, LED and pushbutton port
`timescale 1ns/1ps

module gpio_port import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  bus_req_t   req_i,
  output bus_rsp_t   rsp_o,
  input  logic [7:0] sw_i,
  input  logic       key_i,   // High while pressed
  input  logic       nmia_i,
  output logic [7:0] led_o,
  output logic       irq_o,
  output logic       nmi_o
);

  logic [7:0]        sw_s1;
  logic [7:0]        sw_s2;
  logic [7:0]        sw_q;
  logic              key_s1;
  logic              key_s2;
  logic              key_q;
  gpio_reg_e         reg_sel;
  logic              access;
  logic              press;
  logic [DATA_W-1:0] dat_q;
  logic              ack_q;

  assign reg_sel = gpio_reg_e'(req_i.adr[0]);
  assign access  = req_i.cyc & req_i.stb & ~ack_q;
  assign press   = key_s2 & ~key_q;  // Rising edge of the button

  // Two flop synchronizers that settle during the reset hold
  always_ff @(posedge clk) begin
    sw_s1  <= sw_i;
    sw_s2  <= sw_s1;
    sw_q   <= sw_s2;
    key_s1 <= key_i;
    key_s2 <= key_s1;
    key_q  <= key_s2;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      led_o <= '0;
      irq_o <= 1'b0;
      nmi_o <= 1'b0;
    end else begin
      ack_q <= access;
      irq_o <= (sw_s2 != sw_q);  // One pulse per change
      if (access && req_i.we && reg_sel == GPIO_SW_LED && req_i.sel[0])
        led_o <= req_i.dat[7:0];
      if (nmia_i)
        nmi_o <= 1'b0;
      else if (press)
        nmi_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    case (reg_sel)
      GPIO_SW_LED: dat_q <= {8'h00, sw_s2};
      GPIO_STATUS: dat_q <= {{(DATA_W-1){1'b0}}, key_s2};  // Button level
    endcase
  end

  assign rsp_o.dat = dat_q;
  assign rsp_o.ack = ack_q;

endmodule

/* logic/tick_timer.sv */
// Reloadable tick timer
`timescale 1ns/1ps

module tick_timer import soc_pkg::*; (
  input  logic     clk,
  input  logic     rst_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o,
  output logic     tick_o
);

  logic [DATA_W-1:0] reload_q;
  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] reload_wr;
  logic [DATA_W-1:0] dat_q;
  logic              ack_q;
  logic              access;
  logic              wr_reload;
  timer_reg_e        reg_sel;

  assign reg_sel   = timer_reg_e'(req_i.adr[0]);
  assign access    = req_i.cyc & req_i.stb & ~ack_q;
  assign wr_reload = access & req_i.we & (reg_sel == TMR_RELOAD);

  // Byte lanes merged with the old reload value
  assign reload_wr = {req_i.sel[1] ? req_i.dat[DATA_W-1:8] : reload_q[DATA_W-1:8],
                      req_i.sel[0] ? req_i.dat[7:0]        : reload_q[7:0]};

  // Zero reload parks the counter at zero with no tick
  assign tick_o = (reload_q != '0) && (count_q == '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      reload_q <= '0;
      count_q  <= '0;
    end else begin
      ack_q <= access;
      if (wr_reload) begin
        reload_q <= reload_wr;
        count_q  <= reload_wr;  // Restart from the new value
      end else if (tick_o) begin
        count_q <= reload_q;
      end else if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    dat_q <= (reg_sel == TMR_COUNT) ? count_q : reload_q;
  end

  assign rsp_o.dat = dat_q;
  assign rsp_o.ack = ack_q;

  a_count_range: assert property (@(posedge clk) disable iff (rst_i) count_q <= reload_q);

endmodule

/* logic/int_controller.sv */
// Priority interrupt controller
`timescale 1ns/1ps

module int_controller import soc_pkg::*; (
  input  logic               clk,
  input  logic               rst_i,
  input  logic [NUM_IRQ-1:0] irq_i,   // One cycle request pulses
  input  logic               inta_i,
  output logic               intr_o,
  output logic [IID_W-1:0]   iid_o
);

  logic [NUM_IRQ-1:0] pending_q;
  logic [NUM_IRQ-1:0] clr;
  logic [IID_W-1:0]   iid;

  // Lowest pending line wins
  always_comb begin
    iid = '0;
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (pending_q[i])
        iid = IID_W'(i);
    end
  end

  // Acknowledge retires the line being served
  always_comb begin
    clr = '0;
    if (inta_i)
      clr[iid] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst_i)
      pending_q <= '0;
    else
      pending_q <= (pending_q & ~clr) | irq_i;  // A fresh request outlives the ack
  end

  assign intr_o = |pending_q;
  assign iid_o  = iid;

  // The CPU acknowledges only a raised request
  a_inta_intr: assert property (@(posedge clk) disable iff (rst_i) inta_i |-> intr_o);

endmodule

/* logic/soc_top.sv */
// SoC bus fabric top level
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst_lck,   // Board reset, active low
  input  bus_req_t   m_req_i,
  output bus_rsp_t   m_rsp_o,
  input  logic       inta_i,    // Interrupt acknowledge from the CPU
  input  logic       nmia_i,    // NMI acknowledge from the CPU
  output logic       intr_o,
  output logic       nmi_o,
  input  logic [7:0] sw_i,
  input  logic       key_i,
  output logic [7:0] led_o
);

  logic             sys_rst;
  bus_req_t         rom_req;
  bus_rsp_t         rom_rsp;
  bus_req_t         gpio_req;
  bus_rsp_t         gpio_rsp;
  bus_req_t         tmr_req;
  bus_rsp_t         tmr_rsp;
  logic             tick;
  logic             sw_irq;
  logic [IID_W-1:0] iid;

  reset_debounce i_rst (.clk(clk), .rst_lck(rst_lck), .sys_rst_o(sys_rst));

  bus_switch i_switch (
    .clk(clk), .rst_i(sys_rst),
    .m_req_i(m_req_i), .m_rsp_o(m_rsp_o),
    .rom_req_o(rom_req), .rom_rsp_i(rom_rsp),
    .gpio_req_o(gpio_req), .gpio_rsp_i(gpio_rsp),
    .tmr_req_o(tmr_req), .tmr_rsp_i(tmr_rsp),
    .inta_i(inta_i), .nmia_i(nmia_i), .iid_i(iid)
  );

  boot_rom i_rom (.clk(clk), .rst_i(sys_rst), .req_i(rom_req), .rsp_o(rom_rsp));

  gpio_port i_gpio (
    .clk(clk), .rst_i(sys_rst), .req_i(gpio_req), .rsp_o(gpio_rsp),
    .sw_i(sw_i), .key_i(key_i), .nmia_i(nmia_i),
    .led_o(led_o), .irq_o(sw_irq), .nmi_o(nmi_o)
  );

  tick_timer i_timer (.clk(clk), .rst_i(sys_rst), .req_i(tmr_req), .rsp_o(tmr_rsp),
                      .tick_o(tick));

  int_controller i_pic (
    .clk(clk), .rst_i(sys_rst),
    .irq_i({sw_irq, tick}),  // Line 0 timer, line 1 switches
    .inta_i(inta_i), .intr_o(intr_o), .iid_o(iid)
  );

endmodule

/* include/tb_tasks.svh */
// Testbench reference model and checks
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic bus_rsp_t make_rsp(input logic [DATA_W-1:0] dat, input logic ack);
  bus_rsp_t rsp;
  rsp.dat = dat;
  rsp.ack = ack;
  return rsp;
endfunction

// Word 0 of the image sits at byte 0xfffc0
function automatic logic [DATA_W-1:0] rom_word(input logic [ADR_W-1:0] adr);
  return rom_ref[adr[4:0]];
endfunction

function automatic logic [DATA_W-1:0] vector_ref(input int line);
  return 16'h0008 + 16'(line);  // Vector base 8 plus the line
endfunction

function automatic logic [DATA_W-1:0] nmi_vector_ref();
  return 16'h0002;
endfunction

// Address windows in byte addresses for memory or IO space
function automatic slave_e decode_ref(input logic tga, input logic [ADR_W-1:0] adr);
  logic [ADR_W:0] byte_adr;
  byte_adr = {adr, 1'b0};
  if (!tga && byte_adr >= 20'hfffc0)
    return SLV_ROM;
  if (tga && byte_adr >= 20'h0f100 && byte_adr <= 20'h0f103)
    return SLV_GPIO;
  if (tga && byte_adr >= 20'h00040 && byte_adr <= 20'h00043)
    return SLV_TIMER;
  return SLV_DEFAULT;
endfunction

task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
  if (got !== exp)
    stop_with_error($sformatf("mismatch at %0t: %s got dat=%h ack=%b expected dat=%h ack=%b",
                              $time, name, got.dat, got.ack, exp.dat, exp.ack));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
    stop_with_error($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
endtask

task automatic check_slave(input string name, input slave_e got, input slave_e exp);
  if (got !== exp)
    stop_with_error($sformatf("mismatch at %0t: %s got %s expected %s",
                              $time, name, got.name(), exp.name()));
endtask

task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
  if (got !== exp)
    stop_with_error($sformatf("mismatch at %0t: led_o got %h expected %h", $time, got, exp));
endtask

`endif

/* sim/tb_soc.sv */
// SoC bus fabric testbench
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

  localparam int               TIMEOUT_CYCLES = 4000;  // Whole run needs under 1000 cycles
  localparam int               ROM_READS      = 24;
  localparam logic [ADR_W-1:0] GPIO_WORD      = 19'h07880;  // IO 0xf100
  localparam logic [ADR_W-1:0] GPIO_STAT_WORD = 19'h07881;
  localparam logic [ADR_W-1:0] TMR_WORD       = 19'h00020;  // IO 0x40
  localparam logic [ADR_W-1:0] TMR_CNT_WORD   = 19'h00021;

  logic              clk;
  logic              rst_lck;
  bus_req_t          m_req;
  bus_rsp_t          m_rsp;
  logic              inta;
  logic              nmia;
  logic              intr;
  logic              nmi;
  logic [7:0]        sw;
  logic              key;
  logic [7:0]        led;
  int                seed;
  int                rnd;
  int                cycles = 0;
  logic              in_hold;
  logic [DATA_W-1:0] rom_ref [ROM_WORDS];

`include "tb_tasks.svh"

  soc_top i_dut (
    .clk(clk), .rst_lck(rst_lck), .m_req_i(m_req), .m_rsp_o(m_rsp),
    .inta_i(inta), .nmia_i(nmia), .intr_o(intr), .nmi_o(nmi),
    .sw_i(sw), .key_i(key), .led_o(led)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES)
      stop_with_error("timeout, the test sequence did not finish");
  end

  // Nothing may answer while the system reset is held
  always @(negedge clk) begin
    if (in_hold) begin
      check_bit("m_rsp_o.ack", m_rsp.ack, 1'b0);
      check_bit("intr_o", intr, 1'b0);
      check_bit("nmi_o", nmi, 1'b0);
      check_led(led, 8'h00);
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Request held until ack and followed by one idle cycle
  task automatic bus_access(input logic tga, input logic [ADR_W-1:0] adr, input logic we,
                            input logic [DATA_W-1:0] wdat, output bus_rsp_t rsp);
    int waited;
    waited    = 0;
    m_req.adr = adr;
    m_req.tga = tga;
    m_req.we  = we;
    m_req.sel = 2'b11;
    m_req.dat = wdat;
    m_req.cyc = 1'b1;
    m_req.stb = 1'b1;
    do begin
      @(posedge clk);
      #1;
      waited++;
      if (waited == 1)
        check_slave("i_switch.slv", i_dut.i_switch.slv, decode_ref(tga, adr));
      else if (waited > 8)
        stop_with_error("no ack within 8 cycles of a bus request");
    end while (!m_rsp.ack);
    if (waited != 1)
      stop_with_error($sformatf("mismatch at %0t: ack latency got %0d expected 1",
                                $time, waited));
    rsp       = m_rsp;
    m_req.cyc = 1'b0;
    m_req.stb = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_line(input logic is_nmi, input int limit);
    int n;
    n = 0;
    while (!(is_nmi ? nmi : intr)) begin
      if (n == limit && is_nmi)
        stop_with_error("nmi_o did not rise in time");
      else if (n == limit)
        stop_with_error("intr_o did not rise in time");
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  // One acknowledge cycle with the data sampled mid cycle
  task automatic take_vector(input logic is_nmi, input int line);
    bus_rsp_t rsp;
    nmia = is_nmi;
    inta = !is_nmi;
    @(negedge clk);
    rsp = m_rsp;
    @(posedge clk);
    #1;
    inta = 1'b0;
    nmia = 1'b0;
    if (is_nmi)
      check_rsp("NMI ack data", rsp, make_rsp(nmi_vector_ref(), 1'b0));
    else
      check_rsp("interrupt ack data", rsp, make_rsp(vector_ref(line), 1'b0));
  endtask

  initial begin : main_seq
    bus_rsp_t          rsp;
    logic [ADR_W-1:0]  adr;
    logic [DATA_W-1:0] reload;
    clk     = 1'b0;
    rst_lck = 1'b0;
    m_req   = '0;
    inta    = 1'b0;
    nmia    = 1'b0;
    key     = 1'b0;
    in_hold = 1'b0;
    seed    = 32'hd444;
    rnd     = $random(seed);
    sw      = rnd[7:0];  // Settles through the synchronizers during reset
    $readmemh(ROM_FILE, rom_ref);

    repeat (8) @(posedge clk);
    #1;
    rst_lck   = 1'b1;
    in_hold   = 1'b1;
    m_req.adr = 19'h7ffe0;  // ROM read left pending through the whole hold
    m_req.cyc = 1'b1;
    m_req.stb = 1'b1;
    repeat (RST_HOLD_CYCLES + 1) @(posedge clk);
    #1;
    m_req   = '0;
    in_hold = 1'b0;
    repeat (3) @(posedge clk);
    #1;

    for (int i = 0; i < ROM_READS; i++) begin
      rnd = $random(seed);
      adr = 19'h7ffe0 | {14'h0, rnd[4:0]};
      bus_access(1'b0, adr, 1'b0, '0, rsp);
      check_rsp("ROM read data", rsp, make_rsp(rom_word(adr), 1'b1));
    end

    rnd = $random(seed);
    bus_access(1'b1, GPIO_WORD, 1'b1, rnd[15:0], rsp);
    check_led(led, rnd[7:0]);
    bus_access(1'b1, GPIO_WORD, 1'b0, '0, rsp);
    check_rsp("switch read data", rsp, make_rsp({8'h00, sw}, 1'b1));
    bus_access(1'b1, GPIO_STAT_WORD, 1'b0, '0, rsp);
    check_rsp("button status", rsp, make_rsp(16'h0000, 1'b1));
    bus_access(1'b1, 19'h00180, 1'b0, '0, rsp);  // IO 0x300
    check_rsp("unmapped IO read", rsp, make_rsp(16'h0000, 1'b1));
    bus_access(1'b0, 19'h00800, 1'b0, '0, rsp);  // Memory 0x01000
    check_rsp("unmapped memory read", rsp, make_rsp(16'h0000, 1'b1));

    // Timer alone
    rnd    = $random(seed);
    reload = 16'd16 + {12'h0, rnd[3:0]};
    bus_access(1'b1, TMR_WORD, 1'b1, reload, rsp);
    wait_line(1'b0, 40);
    take_vector(1'b0, 0);
    bus_access(1'b1, TMR_CNT_WORD, 1'b0, '0, rsp);
    if (rsp.dat > reload)
      stop_with_error($sformatf("mismatch at %0t: TMR_COUNT got %0d expected at most %0d",
                                $time, rsp.dat, reload));
    bus_access(1'b1, TMR_WORD, 1'b0, '0, rsp);
    check_rsp("TMR_RELOAD read", rsp, make_rsp(reload, 1'b1));
    bus_access(1'b1, TMR_WORD, 1'b1, 16'h0000, rsp);
    repeat (reload + 2) @(posedge clk);  // Room for one more tick period
    #1;
    check_bit("intr_o with the timer stopped", intr, 1'b0);

    rnd = $random(seed);
    sw  = sw ^ (rnd[7:0] | 8'h01);  // At least one switch moves
    wait_line(1'b0, 8);
    take_vector(1'b0, 1);
    check_bit("intr_o after the switch ack", intr, 1'b0);

    // Timer served first when both lines are pending
    sw = ~sw;
    wait_line(1'b0, 8);
    bus_access(1'b1, TMR_WORD, 1'b1, 16'd3, rsp);
    repeat (8) @(posedge clk);  // Ticks every 4 cycles
    #1;
    bus_access(1'b1, TMR_WORD, 1'b1, 16'h0000, rsp);
    take_vector(1'b0, 0);
    take_vector(1'b0, 1);
    check_bit("intr_o after both acks", intr, 1'b0);

    key = 1'b1;
    wait_line(1'b1, 8);
    bus_access(1'b1, GPIO_STAT_WORD, 1'b0, '0, rsp);
    check_rsp("button status", rsp, make_rsp(16'h0001, 1'b1));
    take_vector(1'b1, 0);
    check_bit("nmi_o after the NMI ack", nmi, 1'b0);
    key = 1'b0;

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* boot_rom.hex */
// Boot ROM image, one 16-bit hex word per line
// Line order is word 0 (byte 0xfffc0) up to word 31 (byte 0xffffe)
fa31
c08e
d88e
d0bc
00fc
e8b0
55ba
00f1
efe4
40a8
0175
74eb
0f24
e6b0
0040
e640
90f4
ebfe
cf90
b402
cd16
3c0d
75f8
c3e9
1234
a55a
5aa5
0102
f00d
beef
00ea
e0ff

/* tb.f */
+incdir+include
logic/soc_pkg.sv
logic/reset_debounce.sv
logic/bus_switch.sv
logic/boot_rom.sv
logic/gpio_port.sv
logic/tick_timer.sv
logic/int_controller.sv
logic/soc_top.sv
sim/tb_soc.sv

/* Makefile */
# Verilator simulation of the SoC bus fabric
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
